// ==== hdl/sd_cmd_pkg.sv ====
// shared SD CMD-path types and frame sizes; rsp_kind value 2'b11 is not defined and reads as short
package sd_cmd_pkg;

  localparam int unsigned CMD_FRAME_BITS    = 48;  // start, tx, index, arg, crc7, end
  localparam int unsigned TX_BODY_BITS      = 40;  // command bits covered by the crc7
  localparam int unsigned RSP_DATA_W        = 120;
  localparam int unsigned CRC_W             = 7;
  localparam int unsigned RSP_LONG_BITS     = 136; // R2 frame
  localparam int unsigned RSP_LONG_HDR_BITS = 8;   // start, tx and reserved bits of R2
  localparam int unsigned RSP_TIMEOUT_TICKS = 64;  // ticks allowed for the card's start bit
  localparam int unsigned LISTEN_GAP_TICKS  = 2;   // end bit to listening

  typedef enum logic [1:0] {
    RSP_NONE  = 2'd0,
    RSP_SHORT = 2'd1,  // 48 bit frame
    RSP_LONG  = 2'd2   // 136 bit frame
  } rsp_kind_e;

  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] arg;
    rsp_kind_e   rsp_kind;
  } cmd_req_t;

  typedef struct packed {
    logic [RSP_DATA_W-1:0] data;
    logic                  crc_ok;
    logic                  end_bit_err;
    logic                  timeout;
  } rsp_result_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_SHIFT,
    TX_CRC,
    TX_END
  } tx_state_e;

  typedef enum logic [2:0] {
    INACTIVE,
    WAIT_FOR_START_BIT,
    SHIFT_IN,
    FINISHED,
    TIMED_OUT
  } rx_state_e;

  typedef enum logic [2:0] {
    REG_ARG    = 3'd0,
    REG_CMD    = 3'd1,
    REG_STATUS = 3'd2,
    REG_RSP0   = 3'd3,
    REG_RSP1   = 3'd4,
    REG_RSP2   = 3'd5,
    REG_RSP3   = 3'd6
  } reg_addr_e;

endpackage

// ==== hdl/crc7_unit.sv ====
// serial CRC7 (x^7+x^3+1), MSB first; clear acts in any cycle, shifting only on enabled ticks
`timescale 1ns/1ps

module crc7_unit (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        clk_en_i,
  input  logic                        clear_i,
  input  logic                        shift_en_i,
  input  logic                        bit_i,
  output logic [sd_cmd_pkg::CRC_W-1:0] crc_o
);
  import sd_cmd_pkg::*;

  logic [CRC_W-1:0] crc_q;
  logic             feedback;

  assign feedback = bit_i ^ crc_q[CRC_W-1];

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      crc_q <= '0;
    end else if (clk_en_i && shift_en_i) begin
      crc_q <= {crc_q[CRC_W-2:0], 1'b0} ^ (feedback ? 7'h09 : 7'h00); // taps x^3 and x^0
    end
  end

  assign crc_o = crc_q;

endmodule

// ==== hdl/cmd_write.sv ====
// sends one 48 bit command frame per start pulse; req_i must stay stable until the frame is done
`timescale 1ns/1ps

module cmd_write (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 clk_en_i,
  input  logic                 start_i,
  input  sd_cmd_pkg::cmd_req_t req_i,
  output logic                 cmd_o,
  output logic                 cmd_oe_o,
  output logic                 start_listening_o,
  output logic                 no_rsp_done_o
);
  import sd_cmd_pkg::*;

  tx_state_e                               state_q;
  logic [TX_BODY_BITS-1:0]                 shreg_q;
  logic [$clog2(TX_BODY_BITS)-1:0]         bit_cnt_q;
  logic [$clog2(LISTEN_GAP_TICKS+1)-1:0]   gap_cnt_q;
  logic                                    cmd_q;
  logic                                    oe_q;
  logic [CRC_W-1:0]                        crc;
  logic                                    crc_shift;
  logic                                    crc_bit;
  logic                                    gap_done;

  assign crc_shift = (state_q == TX_SHIFT) || (state_q == TX_CRC);
  // feeding back the crc MSB turns the generator into a plain shifter
  assign crc_bit   = (state_q == TX_SHIFT) ? shreg_q[TX_BODY_BITS-1] : crc[CRC_W-1];
  assign gap_done  = (gap_cnt_q == LISTEN_GAP_TICKS);

  crc7_unit i_crc7 (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .clk_en_i   (clk_en_i),
    .clear_i    (start_i),
    .shift_en_i (crc_shift),
    .bit_i      (crc_bit),
    .crc_o      (crc)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= TX_IDLE;
      bit_cnt_q <= '0;
      gap_cnt_q <= '0;
      cmd_q     <= 1'b1; // line idles high
      oe_q      <= 1'b0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (start_i) begin
            state_q   <= TX_SHIFT;
            bit_cnt_q <= '0;
          end
        end
        TX_SHIFT: begin
          if (clk_en_i) begin
            cmd_q <= shreg_q[TX_BODY_BITS-1];
            oe_q  <= 1'b1;
            if (bit_cnt_q == TX_BODY_BITS-1) begin
              state_q   <= TX_CRC;
              bit_cnt_q <= '0;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        TX_CRC: begin
          if (clk_en_i) begin
            cmd_q <= crc[CRC_W-1];
            if (bit_cnt_q == CRC_W-1) begin
              state_q   <= TX_END;
              gap_cnt_q <= '0;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        TX_END: begin
          if (clk_en_i) begin
            cmd_q <= 1'b1;                 // end bit, then idle level
            oe_q  <= (gap_cnt_q == '0);    // release after the end bit
            if (gap_done) begin
              state_q <= TX_IDLE;
            end else begin
              gap_cnt_q <= gap_cnt_q + 1'b1;
            end
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == TX_IDLE && start_i) begin
      shreg_q <= {1'b0, 1'b1, req_i.index, req_i.arg}; // start and transmission bits
    end else if (state_q == TX_SHIFT && clk_en_i) begin
      shreg_q <= {shreg_q[TX_BODY_BITS-2:0], 1'b0};
    end
  end

  assign cmd_o    = cmd_q;
  assign cmd_oe_o = oe_q;

  assign start_listening_o = clk_en_i && (state_q == TX_END) && gap_done &&
                             (req_i.rsp_kind != RSP_NONE);
  assign no_rsp_done_o     = clk_en_i && (state_q == TX_END) && gap_done &&
                             (req_i.rsp_kind == RSP_NONE);

endmodule

// ==== hdl/rsp_read.sv ====
// receives a short or R2 response on CMD; no busy (R1b) detection and no format check
`timescale 1ns/1ps

module rsp_read (
  input  logic                    clk_i,
  input  logic                    clk_en_i,
  input  logic                    reset_i,
  input  logic                    cmd_i,
  input  logic                    start_listening_i,
  input  sd_cmd_pkg::rsp_kind_e   rsp_kind_i,
  output logic                    receiving_o,   // start bit seen, frame in progress
  output logic                    rsp_valid_o,
  output sd_cmd_pkg::rsp_result_t result_o
);
  import sd_cmd_pkg::*;

  rx_state_e                              state_q, state_d;
  logic [7:0]                             bit_cnt_q;  // longest frame is 136 bits
  logic [$clog2(RSP_TIMEOUT_TICKS)-1:0]   wait_cnt_q;
  logic [RSP_DATA_W+CRC_W-1:0]            shreg_q;
  logic [RSP_DATA_W+CRC_W-1:0]            rsp_masked;
  logic [CRC_W-1:0]                       crc_calc;
  logic                                   long_rsp;
  logic [7:0]                             shift_start_cnt, crc_first_cnt, crc_last_cnt, done_cnt;
  logic                                   crc_shift, shreg_shift;

  assign long_rsp = (rsp_kind_i == RSP_LONG);

  // counter values are frame position minus one; the start bit is seen in WAIT_FOR_START_BIT
  assign shift_start_cnt = long_rsp ? 8'(RSP_LONG_HDR_BITS-1) : 8'd1;
  assign crc_first_cnt   = long_rsp ? 8'(RSP_LONG_HDR_BITS-1) : 8'd0;
  assign crc_last_cnt    = long_rsp ? 8'(RSP_LONG_HDR_BITS+RSP_DATA_W-2)
                                    : 8'(CMD_FRAME_BITS-CRC_W-3);
  assign done_cnt        = long_rsp ? 8'(RSP_LONG_BITS-3) : 8'(CMD_FRAME_BITS-3);

  always_comb begin
    state_d = state_q;
    case (state_q)
      INACTIVE: begin
        if (start_listening_i) state_d = WAIT_FOR_START_BIT;
      end
      WAIT_FOR_START_BIT: begin
        if (!cmd_i) begin
          state_d = SHIFT_IN;
        end else if (wait_cnt_q == RSP_TIMEOUT_TICKS-1) begin
          state_d = TIMED_OUT;
        end
      end
      SHIFT_IN: begin
        if (bit_cnt_q == done_cnt) state_d = FINISHED;
      end
      default: state_d = INACTIVE; // FINISHED and TIMED_OUT last one tick
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= INACTIVE;
      bit_cnt_q  <= '0;
      wait_cnt_q <= '0;
    end else if (clk_en_i) begin
      state_q    <= state_d;
      bit_cnt_q  <= (state_q == SHIFT_IN) ? bit_cnt_q + 1'b1 : '0;
      wait_cnt_q <= (state_q == WAIT_FOR_START_BIT) ? wait_cnt_q + 1'b1 : '0;
    end
  end

  // short crc covers the start bit, long crc only the 120 payload bits
  assign crc_shift = ((state_q == WAIT_FOR_START_BIT) && !cmd_i && !long_rsp) ||
                     ((state_q == SHIFT_IN) && (bit_cnt_q >= crc_first_cnt) &&
                      (bit_cnt_q <= crc_last_cnt));

  assign shreg_shift = (state_q == SHIFT_IN) && (bit_cnt_q >= shift_start_cnt);

  crc7_unit i_crc7 (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .clk_en_i   (clk_en_i),
    .clear_i    (state_q == INACTIVE),
    .shift_en_i (crc_shift),
    .bit_i      (cmd_i),
    .crc_o      (crc_calc)
  );

  always_ff @(posedge clk_i) begin
    if (clk_en_i) begin
      if (state_q == INACTIVE) begin
        shreg_q <= '0; // short responses leave the upper bits zero
      end else if (shreg_shift) begin
        shreg_q <= {shreg_q[RSP_DATA_W+CRC_W-2:0], cmd_i};
      end
    end
  end

  // keeps the wide output quiet while bits shift through
  assign rsp_masked = (state_q == FINISHED) ? shreg_q : '0;

  assign result_o.data        = rsp_masked[RSP_DATA_W+CRC_W-1:CRC_W];
  assign result_o.crc_ok      = (state_q == FINISHED) && (crc_calc == rsp_masked[CRC_W-1:0]);
  assign result_o.end_bit_err = (state_q == FINISHED) && !cmd_i; // end bit sampled here
  assign result_o.timeout     = (state_q == TIMED_OUT);

  assign rsp_valid_o = clk_en_i && ((state_q == FINISHED) || (state_q == TIMED_OUT));
  assign receiving_o = (state_q == SHIFT_IN) || (state_q == FINISHED);

endmodule

// ==== hdl/cmd_regs.sv ====
// host registers for one command at a time; every write is dropped while busy
`timescale 1ns/1ps

module cmd_regs (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    reg_we_i,
  input  sd_cmd_pkg::reg_addr_e   reg_addr_i,
  input  logic [31:0]             reg_wdata_i,
  input  logic                    rsp_valid_i,
  input  logic                    no_rsp_done_i,
  input  sd_cmd_pkg::rsp_result_t result_i,
  output logic [31:0]             reg_rdata_o,
  output sd_cmd_pkg::cmd_req_t    req_o,
  output logic                    cmd_start_o
);
  import sd_cmd_pkg::*;

  logic [31:0]           arg_q;
  cmd_req_t              req_q;
  logic [RSP_DATA_W-1:0] rsp_data_q;
  logic                  busy_q, done_q, crc_ok_q, end_err_q, timeout_q;
  logic                  start_q;
  logic                  wr_arg, wr_cmd;

  assign wr_arg = reg_we_i && !busy_q && (reg_addr_i == REG_ARG);
  assign wr_cmd = reg_we_i && !busy_q && (reg_addr_i == REG_CMD);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      crc_ok_q  <= 1'b0;
      end_err_q <= 1'b0;
      timeout_q <= 1'b0;
      start_q   <= 1'b0;
    end else begin
      start_q <= wr_cmd; // req_q is valid when the pulse reaches the writer
      if (wr_cmd) begin
        busy_q    <= 1'b1;
        done_q    <= 1'b0;
        crc_ok_q  <= 1'b0;
        end_err_q <= 1'b0;
        timeout_q <= 1'b0;
      end else if (busy_q && rsp_valid_i) begin
        busy_q    <= 1'b0;
        done_q    <= 1'b1;
        crc_ok_q  <= result_i.crc_ok;
        end_err_q <= result_i.end_bit_err;
        timeout_q <= result_i.timeout;
      end else if (busy_q && no_rsp_done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_arg) arg_q <= reg_wdata_i;
    if (wr_cmd) req_q <= '{index: reg_wdata_i[5:0], arg: arg_q,
                           rsp_kind: rsp_kind_e'(reg_wdata_i[9:8])};
    if (busy_q && rsp_valid_i) rsp_data_q <= result_i.data;
  end

  always_comb begin
    case (reg_addr_i)
      REG_ARG:    reg_rdata_o = arg_q;
      REG_CMD:    reg_rdata_o = {22'd0, req_q.rsp_kind, 2'd0, req_q.index};
      REG_STATUS: reg_rdata_o = {27'd0, timeout_q, end_err_q, crc_ok_q, done_q, busy_q};
      REG_RSP0:   reg_rdata_o = rsp_data_q[31:0];
      REG_RSP1:   reg_rdata_o = rsp_data_q[63:32];
      REG_RSP2:   reg_rdata_o = rsp_data_q[95:64];
      REG_RSP3:   reg_rdata_o = {8'd0, rsp_data_q[119:96]};
      default:    reg_rdata_o = '0;
    endcase
  end

  assign req_o       = req_q;
  assign cmd_start_o = start_q;

endmodule

// ==== hdl/sd_cmd_path.sv ====
// SD CMD line host path; clk_en_i is the SD bit strobe and no clock divider is included
`timescale 1ns/1ps

module sd_cmd_path (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  clk_en_i,
  input  logic                  cmd_i,
  input  logic                  reg_we_i,
  input  sd_cmd_pkg::reg_addr_e reg_addr_i,
  input  logic [31:0]           reg_wdata_i,
  output logic                  cmd_o,
  output logic                  cmd_oe_o,
  output logic [31:0]           reg_rdata_o
);
  import sd_cmd_pkg::*;

  cmd_req_t    req;
  rsp_result_t result;
  logic        cmd_start, start_listening, no_rsp_done, rsp_valid;

  cmd_regs i_regs (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .reg_we_i      (reg_we_i),
    .reg_addr_i    (reg_addr_i),
    .reg_wdata_i   (reg_wdata_i),
    .rsp_valid_i   (rsp_valid),
    .no_rsp_done_i (no_rsp_done),
    .result_i      (result),
    .reg_rdata_o   (reg_rdata_o),
    .req_o         (req),
    .cmd_start_o   (cmd_start)
  );

  cmd_write i_write (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .clk_en_i          (clk_en_i),
    .start_i           (cmd_start),
    .req_i             (req),
    .cmd_o             (cmd_o),
    .cmd_oe_o          (cmd_oe_o),
    .start_listening_o (start_listening),
    .no_rsp_done_o     (no_rsp_done)
  );

  rsp_read i_read (
    .clk_i             (clk_i),
    .clk_en_i          (clk_en_i),
    .reset_i           (reset_i),
    .cmd_i             (cmd_i),
    .start_listening_i (start_listening),
    .rsp_kind_i        (req.rsp_kind),
    .receiving_o       (),            // status only, not needed by the host registers
    .rsp_valid_o       (rsp_valid),
    .result_o          (result)
  );

endmodule

// ==== dv/tb_sd_cmd_path.sv ====
// card model answers after a full command frame; run from the project root to find the patterns
`timescale 1ns/1ps

module tb_sd_cmd_path;
  import sd_cmd_pkg::*;

  typedef struct packed {
    logic [5:0]   index;
    logic [31:0]  arg;
    logic [1:0]   kind;
    logic         silent;      // card never answers
    logic [119:0] payload;
    logic [6:0]   crc_xor;     // flips crc bits on the wire
    logic         end_bit;
    logic [4:0]   exp_status;
    logic [119:0] exp_data;
  } pattern_t;

  logic        clk_i;
  logic        reset_i;
  logic        clk_en_i;
  logic        cmd_i;
  logic        reg_we_i;
  reg_addr_e   reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic        cmd_o;
  logic        cmd_oe_o;
  logic [31:0] reg_rdata_o;

  pattern_t    pats[$];
  int          errors = 0;
  bit          loaded = 1'b0;
  logic [1:0]  div_cnt;
  longint      watchdog_ns;
  logic [31:0] status;

  sd_cmd_path DUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .clk_en_i    (clk_en_i),
    .cmd_i       (cmd_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .cmd_o       (cmd_o),
    .cmd_oe_o    (cmd_oe_o),
    .reg_rdata_o (reg_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    div_cnt  = '0;
    clk_en_i = 1'b0;
    forever begin
      @(posedge clk_i);
      div_cnt  <= div_cnt + 1'b1;
      clk_en_i <= (div_cnt == 2'd3); // one tick in four clocks
    end
  end

  initial begin
    wait (loaded);
    watchdog_ns = longint'(pats.size()) * 200 * 4 * 20;
    #(watchdog_ns);
    $display("watchdog expired at %0t, the run did not finish in time", $time);
    $display("Result: FAILED");
    $finish;
  end

  // CRC7 over bits[n-1:0], MSB first, generator x^7+x^3+1
  function automatic logic [6:0] crc7_calc(input logic [135:0] bits, input int n);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = n - 1; i >= 0; i--) begin
      fb  = bits[i] ^ crc[6];
      crc = {crc[5:0], 1'b0};
      if (fb) crc = crc ^ 7'h09;
    end
    return crc;
  endfunction

  task automatic wait_tick();
    do @(negedge clk_i); while (!clk_en_i);
    @(posedge clk_i);
  endtask

  // samples the line just before the tick edge, where it is stable
  task automatic sample_tick(output logic oe, output logic line);
    do @(negedge clk_i); while (!clk_en_i);
    oe   = cmd_oe_o;
    line = cmd_o;
    @(posedge clk_i);
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
    @(posedge clk_i);
    reg_we_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge clk_i);
    reg_we_i    <= 1'b0;
  endtask

  task automatic read_reg(input reg_addr_e addr, output logic [31:0] data);
    @(posedge clk_i);
    reg_addr_i <= addr;
    @(negedge clk_i);
    data = reg_rdata_o;
  endtask

  task automatic check_word(input reg_addr_e addr, input logic [31:0] exp, input int num);
    logic [31:0] got;
    read_reg(addr, got);
    if (got != exp) begin
      $display("Mismatch at %0t: test %0d %s read %h, expected %h",
               $time, num, addr.name(), got, exp);
      errors++;
    end
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    int          kind;
    int          silent;
    int          end_bit;
    string       tok;
    string       rest;
    logic [31:0] idx;
    logic [31:0] arg;
    logic [31:0] xr;
    logic [31:0] st;
    logic [119:0] pl;
    logic [119:0] ed;
    pattern_t    p;
    fd = $fopen("dv/sd_cmd_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/sd_cmd_patterns.txt");
      errors++;
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.substr(0, 0) == "#") begin
        void'($fgets(rest, fd)); // comment line
      end else begin
        void'($sscanf(tok, "%h", idx));
        n = $fscanf(fd, "%h %d %d %h %h %d %h %h", arg, kind, silent, pl, xr, end_bit, st, ed);
        if (n != 8) begin
          $display("pattern line %0d is badly formed", pats.size() + 1);
          errors++;
        end
        p.index      = idx[5:0];
        p.arg        = arg;
        p.kind       = kind[1:0];
        p.silent     = silent[0];
        p.payload    = pl;
        p.crc_xor    = xr[6:0];
        p.end_bit    = end_bit[0];
        p.exp_status = st[4:0];
        p.exp_data   = ed;
        pats.push_back(p);
      end
    end
    $fclose(fd);
  endtask

  task automatic capture_frame(input pattern_t p, input int num);
    logic [47:0] got;
    logic [47:0] exp;
    logic        oe;
    logic        line;
    int          n;
    int          waited;
    got    = '0;
    n      = 0;
    waited = 0;
    exp    = {2'b01, p.index, p.arg, crc7_calc({96'd0, 2'b01, p.index, p.arg}, 40), 1'b1};
    sample_tick(oe, line);
    while (!oe && waited < 8) begin
      waited++;
      sample_tick(oe, line);
    end
    if (!oe) begin
      $display("test %0d: cmd_oe_o never went high after the command write", num);
      errors++;
    end
    while (oe && n < 60) begin
      got = {got[46:0], line};
      n++;
      sample_tick(oe, line);
    end
    if (n != 48) begin
      $display("Mismatch at %0t: test %0d cmd_oe_o high for %0d ticks, expected 48",
               $time, num, n);
      errors++;
    end
    if (got != exp) begin
      $display("Mismatch at %0t: test %0d frame %h, expected %h", $time, num, got, exp);
      errors++;
    end
  endtask

  // card answer, starting on the tick after the writer releases the line
  task automatic send_response(input pattern_t p);
    logic [135:0] bits;
    logic [6:0]   crc;
    int           len;
    int           gap;
    gap = $urandom % 21;
    if (p.kind == 2'd2) begin
      crc  = crc7_calc({16'd0, p.payload}, 120) ^ p.crc_xor;
      bits = {2'b00, 6'h3f, p.payload, crc, p.end_bit}; // R2 header then bits 127..1
      len  = 136;
    end else begin
      crc  = crc7_calc({96'd0, 2'b00, p.payload[37:0]}, 40) ^ p.crc_xor;
      bits = {88'd0, 2'b00, p.payload[37:0], crc, p.end_bit};
      len  = 48;
    end
    repeat (gap) wait_tick();
    for (int i = len - 1; i >= 0; i--) begin
      cmd_i <= bits[i];
      wait_tick();
    end
    cmd_i <= 1'b1; // back to idle
  endtask

  task automatic run_test(input pattern_t p, input int num);
    logic [31:0] st;
    int          polls;
    write_reg(REG_ARG, p.arg);
    write_reg(REG_CMD, {22'd0, p.kind, 2'd0, p.index});
    read_reg(REG_STATUS, st);
    if (st != 32'h1) begin
      $display("Mismatch at %0t: test %0d status %h after command write, expected 1",
               $time, num, st);
      errors++;
    end
    capture_frame(p, num);
    if (!p.silent) send_response(p);
    polls = 0;
    read_reg(REG_STATUS, st);
    while (!st[1] && polls < 1000) begin
      polls++;
      read_reg(REG_STATUS, st);
    end
    if (!st[1]) begin
      $display("test %0d: done was never set in REG_STATUS", num);
      errors++;
    end
    if (st != {27'd0, p.exp_status}) begin
      $display("Mismatch at %0t: test %0d status %h, expected %h",
               $time, num, st, {27'd0, p.exp_status});
      errors++;
    end
    check_word(REG_RSP0, p.exp_data[31:0], num);
    check_word(REG_RSP1, p.exp_data[63:32], num);
    check_word(REG_RSP2, p.exp_data[95:64], num);
    check_word(REG_RSP3, {8'd0, p.exp_data[119:96]}, num);
    check_word(REG_ARG, p.arg, num);
    check_word(REG_CMD, {22'd0, p.kind, 2'd0, p.index}, num);
  endtask

  initial begin
    reset_i     = 1'b1;
    cmd_i       = 1'b1;
    reg_we_i    = 1'b0;
    reg_addr_i  = REG_ARG;
    reg_wdata_i = '0;
    void'($urandom(32'h922));
    load_patterns();
    if (pats.size() == 0) begin
      $display("no test patterns were loaded");
      errors++;
    end
    loaded = (pats.size() != 0);
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    read_reg(REG_STATUS, status);
    if (status != 32'h0 || cmd_oe_o !== 1'b0 || cmd_o !== 1'b1) begin
      $display("Mismatch at %0t: after reset status %h oe %b cmd %b", $time, status,
               cmd_oe_o, cmd_o);
      errors++;
    end
    foreach (pats[i]) run_test(pats[i], i);
    $display("tests run: %0d, errors: %0d", pats.size(), errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/sd_cmd_patterns.txt ====
# idx arg kind(0 none,1 short,2 long) silent payload crc_xor end_bit status exp_data
# hex except kind, silent, end_bit; short payload is index and argument in bits 37..0
11 00001000 1 0 000000000000000000001100000900 00 1 06 000000000000000000001100000900
02 00000000 2 0 0123456789abcdeffedcba98765432 00 1 06 0123456789abcdeffedcba98765432
0d 00010000 1 0 000000000000000000000d00000900 01 1 02 000000000000000000000d00000900
07 12340000 1 0 000000000000000000000700000700 00 0 0e 000000000000000000000700000700
08 000001aa 1 1 000000000000000000000000000000 00 1 12 000000000000000000000000000000
00 00000000 0 1 000000000000000000000000000000 00 1 02 000000000000000000000000000000
09 56780000 2 0 fedcba9876543210aa55aa55aa55aa 40 1 02 fedcba9876543210aa55aa55aa55aa
37 00000000 1 0 000000000000000000003700000120 00 1 06 000000000000000000003700000120

// ==== sd_cmd_path.f ====
hdl/sd_cmd_pkg.sv
hdl/crc7_unit.sv
hdl/cmd_write.sv
hdl/rsp_read.sv
hdl/cmd_regs.sv
hdl/sd_cmd_path.sv
dv/tb_sd_cmd_path.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the SD CMD path testbench with Verilator from the project root
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sd_cmd_path.f \
  --top-module tb_sd_cmd_path -Mdir "$BUILD_DIR" -o tb_sd_cmd_path
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_sd_cmd_path" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
